// ==== rtl/ising_geom_pkg.sv ====
/*
 * problem geometry of the Ising compute path
 * spin count, J and h entry widths, rows per weight word
 * derived row, word and address widths
 */

package ising_geom_pkg;

    localparam int NUM_SPIN    = 16;
    localparam int BITJ        = 4;
    localparam int PARALLELISM = 4;
    localparam int SCALING_BIT = 2;

    // one J row holds one signed entry per spin
    localparam int ROW_BITS     = NUM_SPIN * BITJ;
    localparam int DATA_J_BIT   = ROW_BITS * PARALLELISM;
    localparam int DATA_H_BIT   = NUM_SPIN * BITJ;
    localparam int J_ADDR_WIDTH = $clog2(NUM_SPIN / PARALLELISM);
    localparam int NUM_J_WORDS  = NUM_SPIN / PARALLELISM;

endpackage

// ==== rtl/ising_ctrl_pkg.sv ====
/*
 * control widths of the Ising compute path
 * energy width, weight buffer depth and its pointer widths
 * flip-icon address width, cycle counter width
 */

package ising_ctrl_pkg;

    localparam int ENERGY_BIT          = 32;
    localparam int FETCH_DEPTH         = 2;
    localparam int FETCH_PTR_BITS      = $clog2(FETCH_DEPTH);
    localparam int FETCH_CNT_BITS      = $clog2(FETCH_DEPTH + 1);
    localparam int ICON_ADDR_WIDTH     = 8;
    localparam int CC_COUNTER_BITWIDTH = 32;

endpackage

// ==== rtl/ising_if.sv ====
/*
 * spin_energy_if: candidate request and energy response
 * weight_stream_if: J word stream with last-word tag
 */

`timescale 1ns/1ps

interface spin_energy_if import ising_geom_pkg::*, ising_ctrl_pkg::*; ();

    logic                         req_valid;
    logic                         req_ready;
    logic [NUM_SPIN-1:0]          spin;
    logic                         rsp_valid;
    logic                         rsp_ready;
    logic signed [ENERGY_BIT-1:0] energy;

    modport requester (
        output req_valid, spin, rsp_ready,
        input  req_ready, rsp_valid, energy
    );

    modport evaluator (
        input  req_valid, spin, rsp_ready,
        output req_ready, rsp_valid, energy
    );

endinterface

interface weight_stream_if import ising_geom_pkg::*; ();

    logic                  valid;
    logic                  ready;
    logic [DATA_J_BIT-1:0] data;
    // high on the word of the final address of a pass
    logic                  last;

    modport source (output valid, data, last, input ready);
    modport sink   (input valid, data, last, output ready);

endinterface

// ==== rtl/weight_fetch_fifo.sv ====
/*
 * weight fetcher
 * cyclic weight-memory reads, one pass per energy evaluation
 * small buffer of returned words with last-address tag
 */

`timescale 1ns/1ps

module weight_fetch_fifo import ising_geom_pkg::*, ising_ctrl_pkg::*; (
    input  logic                    clk_i,
    input  logic                    reset_i,
    output logic                    weight_ren_o,
    output logic [J_ADDR_WIDTH-1:0] weight_raddr_o,
    input  logic [DATA_J_BIT-1:0]   weight_rdata_i,
    weight_stream_if.source         wstream
);

    logic [DATA_J_BIT-1:0]     buf_data [FETCH_DEPTH];
    logic                      buf_last [FETCH_DEPTH];
    logic [FETCH_PTR_BITS-1:0] wr_ptr_q;
    logic [FETCH_PTR_BITS-1:0] rd_ptr_q;
    logic [FETCH_CNT_BITS-1:0] count_q;
    logic [FETCH_CNT_BITS-1:0] count_nxt;
    logic [J_ADDR_WIDTH-1:0]   raddr_q;
    logic                      ret_valid_q;
    logic                      ret_last_q;
    logic                      pop;
    logic                      issue;

    assign pop       = wstream.valid & wstream.ready;
    assign count_nxt = count_q + ret_valid_q - pop;
    // the read issued last cycle is still in flight
    assign issue     = (count_nxt + weight_ren_o) < FETCH_DEPTH;

    assign weight_raddr_o = raddr_q;
    assign wstream.valid  = (count_q != '0);
    assign wstream.data   = buf_data[rd_ptr_q];
    assign wstream.last   = buf_last[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            weight_ren_o <= 1'b0;
            raddr_q      <= '0;
            ret_valid_q  <= 1'b0;
            ret_last_q   <= 1'b0;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
        end else begin
            weight_ren_o <= issue;
            ret_valid_q  <= weight_ren_o;
            ret_last_q   <= weight_ren_o && (raddr_q == J_ADDR_WIDTH'(NUM_J_WORDS - 1));
            if (weight_ren_o) begin
                raddr_q <= (raddr_q == J_ADDR_WIDTH'(NUM_J_WORDS - 1)) ? '0 : raddr_q + 1'b1;
            end
            if (ret_valid_q) begin
                wr_ptr_q <= (wr_ptr_q == FETCH_PTR_BITS'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == FETCH_PTR_BITS'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_nxt;
        end
    end

    // returned word lands one cycle after its read enable
    always_ff @(posedge clk_i) begin
        if (ret_valid_q) begin
            buf_data[wr_ptr_q] <= weight_rdata_i;
            buf_last[wr_ptr_q] <= ret_last_q;
        end
    end

endmodule

// ==== rtl/partial_energy.sv ====
/*
 * partial energy of one row group
 * signed J-times-spin sums per row plus scaled h term
 * each row result weighted by that row's own spin sign
 */

`timescale 1ns/1ps

module partial_energy import ising_geom_pkg::*, ising_ctrl_pkg::*; (
    input  logic [J_ADDR_WIDTH-1:0]      group_i,
    input  logic [DATA_J_BIT-1:0]        rows_i,
    input  logic [NUM_SPIN-1:0]          spin_i,
    input  logic [DATA_H_BIT-1:0]        h_bias_i,
    input  logic [SCALING_BIT-1:0]       h_scaling_i,
    output logic signed [ENERGY_BIT-1:0] sum_o
);

    always_comb begin
        logic signed [ENERGY_BIT-1:0] total;
        logic signed [ENERGY_BIT-1:0] row_acc;
        logic signed [ENERGY_BIT-1:0] j_val;
        logic signed [ENERGY_BIT-1:0] h_val;
        int                           idx;

        total = '0;
        for (int r = 0; r < PARALLELISM; r++) begin
            idx     = int'(group_i) * PARALLELISM + r;
            row_acc = '0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                j_val   = $signed(rows_i[r*ROW_BITS + j*BITJ +: BITJ]);
                row_acc = spin_i[j] ? row_acc + j_val : row_acc - j_val;
            end
            h_val   = $signed(h_bias_i[idx*BITJ +: BITJ]);
            h_val   = h_val <<< h_scaling_i;
            row_acc = row_acc + h_val;
            total   = spin_i[idx] ? total + row_acc : total - row_acc;
        end
        sum_o = total;
    end

endmodule

// ==== rtl/energy_monitor.sv ====
/*
 * energy monitor
 * latches a candidate spin, consumes one pass of J words,
 * accumulates the group partial sums and returns the energy
 */

`timescale 1ns/1ps

module energy_monitor import ising_geom_pkg::*, ising_ctrl_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    spin_energy_if.evaluator       req,
    weight_stream_if.sink          wstream,
    input  logic [DATA_H_BIT-1:0]  h_bias_i,
    input  logic [SCALING_BIT-1:0] h_scaling_i
);

    logic                         busy_q;
    logic                         rsp_valid_q;
    logic [NUM_SPIN-1:0]          spin_q;
    logic [J_ADDR_WIDTH-1:0]      group_q;
    logic signed [ENERGY_BIT-1:0] acc_q;
    logic signed [ENERGY_BIT-1:0] part_sum;
    logic                         req_hs;
    logic                         w_hs;
    logic                         rsp_hs;

    // one candidate at a time, next one only after the response is taken
    assign req.req_ready = ~busy_q & ~rsp_valid_q;
    assign req.rsp_valid = rsp_valid_q;
    assign req.energy    = acc_q;
    assign wstream.ready = busy_q;

    assign req_hs = req.req_valid & req.req_ready;
    assign w_hs   = wstream.valid & wstream.ready;
    assign rsp_hs = req.rsp_valid & req.rsp_ready;

    partial_energy u_partial_energy (
        .group_i     (group_q),
        .rows_i      (wstream.data),
        .spin_i      (spin_q),
        .h_bias_i    (h_bias_i),
        .h_scaling_i (h_scaling_i),
        .sum_o       (part_sum)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            group_q     <= '0;
        end else begin
            if (req_hs) begin
                busy_q  <= 1'b1;
                group_q <= '0;
            end else if (w_hs) begin
                group_q <= group_q + 1'b1;
                if (wstream.last) begin
                    busy_q      <= 1'b0;
                    rsp_valid_q <= 1'b1;
                end
            end
            if (rsp_hs) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    // accumulator takes the last word on the same edge rsp_valid rises
    always_ff @(posedge clk_i) begin
        if (req_hs) begin
            spin_q <= req.spin;
            acc_q  <= '0;
        end else if (w_hs) begin
            acc_q <= acc_q + part_sum;
        end
    end

endmodule

// ==== rtl/flip_manager.sv ====
/*
 * flip manager
 * start and config edge detection, accepted spin and energy,
 * flip-icon reads, candidate requests and accept decisions,
 * compute-cycle counter with sticky overflow
 */

`timescale 1ns/1ps

module flip_manager import ising_geom_pkg::*, ising_ctrl_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           config_valid_i,
    input  logic [NUM_SPIN-1:0]            spin_initial_i,
    input  logic                           cmpt_en_i,
    input  logic                           en_comparison_i,
    input  logic [ICON_ADDR_WIDTH-1:0]     icon_last_i,
    output logic                           flip_ren_o,
    output logic [ICON_ADDR_WIDTH-1:0]     flip_raddr_o,
    input  logic [NUM_SPIN-1:0]            flip_rdata_i,
    spin_energy_if.requester               req,
    output logic                           update_o,
    output logic [NUM_SPIN-1:0]            spin_o,
    output logic [ENERGY_BIT-1:0]          energy_o,
    output logic                           cmpt_idle_o,
    output logic [CC_COUNTER_BITWIDTH-1:0] cmpt_cycle_cnt_o,
    output logic                           cmpt_cycle_cnt_overflow_o
);

    logic                         config_dly_q;
    logic                         cmpt_en_dly_q;
    logic                         config_pulse;
    logic                         start_pulse;
    logic                         run_start;
    logic                         running_q;
    logic                         baseline_q;
    logic                         req_valid_q;
    logic                         icon_vld_q;
    logic [ICON_ADDR_WIDTH-1:0]   icon_addr_q;
    logic [NUM_SPIN-1:0]          cand_q;
    logic [NUM_SPIN-1:0]          spin_q;
    logic signed [ENERGY_BIT-1:0] energy_q;
    logic                         rsp_hs;
    logic                         accept;
    logic                         more_icons;

    // level inputs turned into single-cycle pulses
    assign config_pulse = config_valid_i & ~config_dly_q;
    assign start_pulse  = cmpt_en_i & ~cmpt_en_dly_q;
    assign run_start    = start_pulse & ~running_q;

    assign rsp_hs     = req.rsp_valid & req.rsp_ready;
    // baseline energy is always taken
    assign accept     = baseline_q | ~en_comparison_i | (req.energy < energy_q);
    assign more_icons = icon_addr_q < icon_last_i;

    assign req.req_valid = req_valid_q;
    assign req.spin      = cand_q;
    assign req.rsp_ready = running_q;
    assign flip_raddr_o  = icon_addr_q;
    assign cmpt_idle_o   = ~running_q;
    assign spin_o        = spin_q;
    assign energy_o      = energy_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            config_dly_q  <= 1'b0;
            cmpt_en_dly_q <= 1'b0;
            running_q     <= 1'b0;
            baseline_q    <= 1'b0;
            req_valid_q   <= 1'b0;
            flip_ren_o    <= 1'b0;
            icon_vld_q    <= 1'b0;
            icon_addr_q   <= '0;
            update_o      <= 1'b0;
        end else begin
            config_dly_q  <= config_valid_i;
            cmpt_en_dly_q <= cmpt_en_i;
            update_o      <= rsp_hs & accept;
            icon_vld_q    <= flip_ren_o;
            flip_ren_o    <= rsp_hs & more_icons;
            if (flip_ren_o) begin
                icon_addr_q <= icon_addr_q + 1'b1;
            end
            if (run_start) begin
                running_q   <= 1'b1;
                baseline_q  <= 1'b1;
                req_valid_q <= 1'b1;
                icon_addr_q <= '0;
            end else begin
                if (req.req_valid && req.req_ready) begin
                    req_valid_q <= 1'b0;
                end
                if (icon_vld_q) begin
                    req_valid_q <= 1'b1;
                end
                if (rsp_hs) begin
                    baseline_q <= 1'b0;
                    if (!more_icons) begin
                        running_q <= 1'b0;
                    end
                end
            end
        end
    end

    // accepted state and candidate
    always_ff @(posedge clk_i) begin
        if (config_pulse && !running_q) begin
            spin_q <= spin_initial_i;
        end else if (rsp_hs && accept) begin
            spin_q   <= cand_q;
            energy_q <= req.energy;
        end
        if (run_start) begin
            cand_q <= spin_q;
        end else if (icon_vld_q) begin
            cand_q <= spin_q ^ flip_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || run_start) begin
            cmpt_cycle_cnt_o          <= '0;
            cmpt_cycle_cnt_overflow_o <= 1'b0;
        end else if (running_q) begin
            cmpt_cycle_cnt_o <= cmpt_cycle_cnt_o + 1'b1;
            if (&cmpt_cycle_cnt_o) begin
                cmpt_cycle_cnt_overflow_o <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/ising_macro_top.sv ====
/*
 * top of the Ising compute path
 * flip manager, energy monitor and weight fetcher
 * joined by the request and weight stream interfaces
 */

`timescale 1ns/1ps

module ising_macro_top import ising_geom_pkg::*, ising_ctrl_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           config_valid_i,
    input  logic [NUM_SPIN-1:0]            spin_initial_i,
    input  logic                           cmpt_en_i,
    input  logic                           en_comparison_i,
    input  logic [ICON_ADDR_WIDTH-1:0]     icon_last_i,
    output logic                           flip_ren_o,
    output logic [ICON_ADDR_WIDTH-1:0]     flip_raddr_o,
    input  logic [NUM_SPIN-1:0]            flip_rdata_i,
    output logic                           weight_ren_o,
    output logic [J_ADDR_WIDTH-1:0]        weight_raddr_o,
    input  logic [DATA_J_BIT-1:0]          weight_rdata_i,
    input  logic [DATA_H_BIT-1:0]          h_bias_i,
    input  logic [SCALING_BIT-1:0]         h_scaling_i,
    output logic                           cmpt_idle_o,
    output logic                           update_o,
    output logic [NUM_SPIN-1:0]            spin_o,
    output logic [ENERGY_BIT-1:0]          energy_o,
    output logic [CC_COUNTER_BITWIDTH-1:0] cmpt_cycle_cnt_o,
    output logic                           cmpt_cycle_cnt_overflow_o
);

    spin_energy_if   se_if ();
    weight_stream_if ws_if ();

    flip_manager u_flip_manager (
        .clk_i                     (clk_i),
        .reset_i                   (reset_i),
        .config_valid_i            (config_valid_i),
        .spin_initial_i            (spin_initial_i),
        .cmpt_en_i                 (cmpt_en_i),
        .en_comparison_i           (en_comparison_i),
        .icon_last_i               (icon_last_i),
        .flip_ren_o                (flip_ren_o),
        .flip_raddr_o              (flip_raddr_o),
        .flip_rdata_i              (flip_rdata_i),
        .req                       (se_if.requester),
        .update_o                  (update_o),
        .spin_o                    (spin_o),
        .energy_o                  (energy_o),
        .cmpt_idle_o               (cmpt_idle_o),
        .cmpt_cycle_cnt_o          (cmpt_cycle_cnt_o),
        .cmpt_cycle_cnt_overflow_o (cmpt_cycle_cnt_overflow_o)
    );

    energy_monitor u_energy_monitor (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req         (se_if.evaluator),
        .wstream     (ws_if.sink),
        .h_bias_i    (h_bias_i),
        .h_scaling_i (h_scaling_i)
    );

    weight_fetch_fifo u_weight_fetch_fifo (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .weight_ren_o   (weight_ren_o),
        .weight_raddr_o (weight_raddr_o),
        .weight_rdata_i (weight_rdata_i),
        .wstream        (ws_if.source)
    );

endmodule

// ==== dv/ising_macro_asserts.sv ====
/*
 * concurrent assertions for the Ising compute path
 * request and response taken in the cycle they are offered
 * weight stream valid and word stable until ready
 * quiet outputs while reset is held
 */

`timescale 1ns/1ps

module ising_macro_asserts (
    input logic      clk_i,
    input logic      reset_i,
    input logic      update_i,
    input logic      weight_ren_i,
    input logic      flip_ren_i,
    spin_energy_if   se_if,
    weight_stream_if ws_if
);

    // with one candidate in flight neither side waits for ready
    req_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
        se_if.req_valid |-> se_if.req_ready)
        else $error("candidate request offered while the energy monitor was busy");

    rsp_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
        se_if.rsp_valid |-> se_if.rsp_ready)
        else $error("energy response not taken in the cycle it was offered");

    // weight words must survive a stalled monitor
    wstream_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
        ws_if.valid && !ws_if.ready |=>
            ws_if.valid && $stable(ws_if.data) && $stable(ws_if.last))
        else $error("weight stream valid dropped or word changed before ready");

    reset_quiet_a: assert property (@(posedge clk_i)
        reset_i && $past(reset_i) |-> !update_i && !weight_ren_i && !flip_ren_i)
        else $error("update or read enable active during reset");

endmodule

bind ising_macro_top ising_macro_asserts u_asserts (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .update_i     (update_o),
    .weight_ren_i (weight_ren_o),
    .flip_ren_i   (flip_ren_o),
    .se_if        (se_if),
    .ws_if        (ws_if)
);

// ==== dv/ising_macro_tb.sv ====
/*
 * testbench for the Ising compute path
 * clock, reset, behavioral weight and flip-icon memories,
 * random stimulus, energy and greedy-run reference model, checks
 */

`timescale 1ns/1ps

module ising_macro_tb import ising_geom_pkg::*, ising_ctrl_pkg::*; ();

    localparam int RUN_LIMIT = 5000;

    logic                           clk_i;
    logic                           reset_i;
    logic                           config_valid_i;
    logic [NUM_SPIN-1:0]            spin_initial_i;
    logic                           cmpt_en_i;
    logic                           en_comparison_i;
    logic [ICON_ADDR_WIDTH-1:0]     icon_last_i;
    logic                           flip_ren_o;
    logic [ICON_ADDR_WIDTH-1:0]     flip_raddr_o;
    logic [NUM_SPIN-1:0]            flip_rdata_i;
    logic                           weight_ren_o;
    logic [J_ADDR_WIDTH-1:0]        weight_raddr_o;
    logic [DATA_J_BIT-1:0]          weight_rdata_i;
    logic [DATA_H_BIT-1:0]          h_bias_i;
    logic [SCALING_BIT-1:0]         h_scaling_i;
    logic                           cmpt_idle_o;
    logic                           update_o;
    logic [NUM_SPIN-1:0]            spin_o;
    logic [ENERGY_BIT-1:0]          energy_o;
    logic [CC_COUNTER_BITWIDTH-1:0] cmpt_cycle_cnt_o;
    logic                           cmpt_cycle_cnt_overflow_o;

    logic [DATA_J_BIT-1:0] weight_mem [NUM_J_WORDS];
    logic [NUM_SPIN-1:0]   icon_mem [2**ICON_ADDR_WIDTH];
    logic [DATA_J_BIT-1:0] w_pend = '0;
    logic [NUM_SPIN-1:0]   f_pend = '0;
    integer                seed;
    int                    err_cnt = 0;
    int                    check_cnt = 0;
    int                    test_cnt = 0;
    int                    test_err0 = 0;
    int                    update_cnt = 0;
    int                    idle_cycles = 0;
    logic                  flip_ren_seen = 1'b0;

    ising_macro_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // memories answer in the cycle after the read enable
    always @(negedge clk_i) begin
        weight_rdata_i = w_pend;
        flip_rdata_i   = f_pend;
        if (weight_ren_o === 1'b1) begin
            w_pend = weight_mem[weight_raddr_o];
        end
        if (flip_ren_o === 1'b1) begin
            f_pend = icon_mem[flip_raddr_o];
        end
    end

    always @(negedge clk_i) begin
        if (!reset_i) begin
            if (update_o) begin
                update_cnt++;
            end
            if (!cmpt_idle_o) begin
                idle_cycles++;
            end
            if (flip_ren_o) begin
                flip_ren_seen = 1'b1;
            end
        end
    end

    // Ising energy with spin bit 1 as +1 and bit 0 as -1
    function automatic int model_energy(input logic [NUM_SPIN-1:0] s);
        logic [DATA_J_BIT-1:0] word;
        int                    e;
        int                    row;
        int                    jv;
        int                    hv;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            word = weight_mem[i / PARALLELISM];
            row  = 0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                jv  = $signed(word[(i % PARALLELISM) * ROW_BITS + j * BITJ +: BITJ]);
                row = row + jv * (s[j] ? 1 : -1);
            end
            hv = $signed(h_bias_i[i * BITJ +: BITJ]);
            e  = e + (s[i] ? 1 : -1) * (row + (hv <<< h_scaling_i));
        end
        return e;
    endfunction

    task automatic model_run(input logic [NUM_SPIN-1:0] start, input logic cmp, input int last,
                             output logic [NUM_SPIN-1:0] fin_s, output int fin_e,
                             output int n_upd);
        logic [NUM_SPIN-1:0] cand;
        int                  e;
        fin_s = start;
        fin_e = model_energy(start);
        n_upd = 1;
        for (int a = 0; a < last; a++) begin
            cand = fin_s ^ icon_mem[a];
            e    = model_energy(cand);
            if (!cmp || e < fin_e) begin
                fin_s = cand;
                fin_e = e;
                n_upd++;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic load_spin(input logic [NUM_SPIN-1:0] s);
        spin_initial_i = s;
        config_valid_i = 1'b1;
        repeat (2) @(negedge clk_i);
        config_valid_i = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic do_run(input logic hold_en);
        int t;
        update_cnt  = 0;
        idle_cycles = 0;
        cmpt_en_i   = 1'b1;
        t = 0;
        while (cmpt_idle_o && t < RUN_LIMIT) begin
            @(negedge clk_i);
            t++;
        end
        assert (!cmpt_idle_o) else begin
            $display("run did not start within %0d cycles", RUN_LIMIT);
            err_cnt++;
        end
        if (!hold_en) begin
            cmpt_en_i = 1'b0;
        end
        t = 0;
        while (!cmpt_idle_o && t < RUN_LIMIT) begin
            @(negedge clk_i);
            t++;
        end
        assert (cmpt_idle_o) else begin
            $display("run did not finish within %0d cycles", RUN_LIMIT);
            err_cnt++;
        end
        // the last update pulse shares its cycle with the idle edge
        @(negedge clk_i);
    endtask

    task automatic run_and_check(input logic [NUM_SPIN-1:0] start, input logic cmp,
                                 input int last, input logic hold_en,
                                 output logic [NUM_SPIN-1:0] fin_s);
        int fin_e;
        int n_upd;
        en_comparison_i = cmp;
        icon_last_i     = last;
        model_run(start, cmp, last, fin_s, fin_e, n_upd);
        do_run(hold_en);
        check_value("spin_o", spin_o, fin_s);
        check_value("energy_o", energy_o, $unsigned(fin_e));
        check_value("update count", update_cnt, n_upd);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
        test_err0 = err_cnt;
    endtask

    initial begin
        logic [NUM_SPIN-1:0] s0;
        logic [NUM_SPIN-1:0] fin_s;
        logic [NUM_SPIN-1:0] xor_all;
        int                  n;
        seed            = 84581;
        reset_i         = 1'b1;
        config_valid_i  = 1'b0;
        spin_initial_i  = '0;
        cmpt_en_i       = 1'b0;
        en_comparison_i = 1'b0;
        icon_last_i     = '0;
        flip_rdata_i    = '0;
        weight_rdata_i  = '0;
        for (int w = 0; w < NUM_J_WORDS; w++) begin
            for (int k = 0; k < DATA_J_BIT / 32; k++) begin
                weight_mem[w][k*32 +: 32] = $random(seed);
            end
        end
        for (int a = 0; a < 2**ICON_ADDR_WIDTH; a++) begin
            icon_mem[a] = $random(seed);
        end
        h_bias_i    = {$random(seed), $random(seed)};
        h_scaling_i = $random(seed);
        repeat (10) @(negedge clk_i);
        reset_i = 1'b0;
        repeat (3) @(negedge clk_i);

        check_value("cmpt_idle_o", cmpt_idle_o, 1);
        check_value("update_o", update_o, 0);
        assert (!flip_ren_seen) else begin
            $display("flip-icon read issued before any start");
            err_cnt++;
        end
        finish_test("reset state");

        s0 = $random(seed);
        load_spin(s0);
        run_and_check(s0, 1'b1, 0, 1'b0, fin_s);
        finish_test("baseline only");

        s0 = $random(seed);
        load_spin(s0);
        run_and_check(s0, 1'b1, 24, 1'b0, fin_s);
        finish_test("greedy comparison");

        s0 = $random(seed);
        load_spin(s0);
        run_and_check(s0, 1'b0, 12, 1'b0, fin_s);
        xor_all = s0;
        for (int a = 0; a < 12; a++) begin
            xor_all = xor_all ^ icon_mem[a];
        end
        check_value("spin_o", spin_o, xor_all);
        finish_test("comparison off");

        // level inputs held high start one load and one run
        s0             = $random(seed);
        spin_initial_i = s0;
        config_valid_i = 1'b1;
        repeat (3) @(negedge clk_i);
        run_and_check(s0, 1'b1, 8, 1'b1, fin_s);
        n = update_cnt;
        repeat (20) @(negedge clk_i);
        check_value("update count", update_cnt, n);
        check_value("cmpt_idle_o", cmpt_idle_o, 1);
        spin_initial_i = ~s0;
        repeat (5) @(negedge clk_i);
        check_value("spin_o", spin_o, fin_s);
        config_valid_i = 1'b0;
        cmpt_en_i      = 1'b0;
        repeat (2) @(negedge clk_i);
        finish_test("held start and config");

        check_value("cmpt_cycle_cnt_o", cmpt_cycle_cnt_o, idle_cycles);
        check_value("cmpt_cycle_cnt_overflow_o", cmpt_cycle_cnt_overflow_o, 0);
        finish_test("cycle counter");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/ising_geom_pkg.sv
rtl/ising_ctrl_pkg.sv
rtl/ising_if.sv
rtl/weight_fetch_fifo.sv
rtl/partial_energy.sv
rtl/energy_monitor.sv
rtl/flip_manager.sv
rtl/ising_macro_top.sv
dv/ising_macro_asserts.sv
dv/ising_macro_tb.sv

// ==== Bender.yml ====
package:
  name: ising_macro

sources:
  - rtl/ising_geom_pkg.sv
  - rtl/ising_ctrl_pkg.sv
  - rtl/ising_if.sv
  - rtl/weight_fetch_fifo.sv
  - rtl/partial_energy.sv
  - rtl/energy_monitor.sv
  - rtl/flip_manager.sv
  - rtl/ising_macro_top.sv
  - target: test
    files:
      - dv/ising_macro_asserts.sv
      - dv/ising_macro_tb.sv
